// ==== source/rv64_core_pkg.sv ====
// enums, control word and constants shared by the rv64 core
`default_nettype none

package rv64_core_pkg;

  localparam int unsigned XLEN      = 64;
  localparam int unsigned REG_IDX_W = 5;
  localparam int unsigned NUM_REGS  = 32;

  localparam logic [XLEN-1:0] RESET_PC = '0;

  // operand b select
  localparam logic [1:0] SRC_B_RS2  = 2'd0;
  localparam logic [1:0] SRC_B_IMM  = 2'd1;
  localparam logic [1:0] SRC_B_FOUR = 2'd2;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

  typedef enum logic [6:0] {
    OP        = 7'b0110011,
    OP_IMM    = 7'b0010011,
    OP_32     = 7'b0111011,
    OP_IMM_32 = 7'b0011011,
    LUI       = 7'b0110111,
    AUIPC     = 7'b0010111,
    JAL       = 7'b1101111,
    JALR      = 7'b1100111,
    BRANCH    = 7'b1100011,
    LOAD      = 7'b0000011,
    STORE     = 7'b0100011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD    = 4'b0000,
    ALU_SUB    = 4'b0001,
    ALU_SLT    = 4'b0010,
    ALU_SLTU   = 4'b0011,
    ALU_XOR    = 4'b0100,
    ALU_AND    = 4'b0101,
    ALU_OR     = 4'b0110,
    ALU_SLL    = 4'b0111,
    ALU_SRL    = 4'b1000,
    ALU_SRA    = 4'b1001,
    ALU_COPY_B = 4'b1111
  } alu_op_e;

  // low three bits follow the execute unit codes, bit 3 marks unsigned compare
  typedef enum logic [3:0] {
    BR_NONE = 4'b0000,
    BR_JAL  = 4'b0001,
    BR_JALR = 4'b0010,
    BR_EQ   = 4'b0100,
    BR_NE   = 4'b0101,
    BR_LT   = 4'b0110,
    BR_GE   = 4'b0111,
    BR_LTU  = 4'b1110,
    BR_GEU  = 4'b1111
  } branch_e;

  typedef enum logic [2:0] {
    LD_B  = 3'b000,
    LD_BU = 3'b001,
    LD_H  = 3'b010,
    LD_HU = 3'b011,
    LD_W  = 3'b100,
    LD_WU = 3'b101,
    LD_D  = 3'b110
  } mem_op_e;

  typedef struct packed {
    logic       alu_a_pc;
    logic [1:0] alu_b_sel;
    alu_op_e    alu_op;
    logic       word_op;
    branch_e    branch;
    mem_op_e    mem_op;
    logic       mem_read;
    logic       mem_write;
    logic       reg_write;
    logic       illegal;
  } ctrl_t;

endpackage

`default_nettype wire

// ==== source/inst_decoder.sv ====
// instruction decoder producing the control word and the immediate
`default_nettype none

module inst_decoder import rv64_core_pkg::*; (
  input  wire logic [31:0]          i_inst,
  output ctrl_t                     o_ctrl,
  output logic [XLEN-1:0]           o_imm,
  output logic [REG_IDX_W-1:0]      o_rs1_idx,
  output logic [REG_IDX_W-1:0]      o_rs2_idx,
  output logic [REG_IDX_W-1:0]      o_rd_idx
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       legal;
  ctrl_t      ctrl;

  // alt picks sub for f3 000 and sra for f3 101
  function automatic alu_op_e alu_of_f3(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  assign opcode    = i_inst[6:0];
  assign funct3    = i_inst[14:12];
  assign funct7    = i_inst[31:25];
  assign o_rs1_idx = i_inst[19:15];
  assign o_rs2_idx = i_inst[24:20];
  assign o_rd_idx  = i_inst[11:7];

  always_comb begin
    case (opcode)
      LUI, AUIPC: o_imm = {{32{i_inst[31]}}, i_inst[31:12], 12'b0};
      JAL:        o_imm = {{44{i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};
      BRANCH:     o_imm = {{52{i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
      STORE:      o_imm = {{52{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
      default:    o_imm = {{52{i_inst[31]}}, i_inst[31:20]};
    endcase
  end

  always_comb begin
    legal          = 1'b1;
    ctrl.alu_a_pc  = 1'b0;
    ctrl.alu_b_sel = SRC_B_IMM;
    ctrl.alu_op    = ALU_ADD;
    ctrl.word_op   = 1'b0;
    ctrl.branch    = BR_NONE;
    ctrl.mem_op    = LD_D;
    ctrl.mem_read  = 1'b0;
    ctrl.mem_write = 1'b0;
    ctrl.reg_write = 1'b0;
    ctrl.illegal   = 1'b0;
    case (opcode)
      OP, OP_32: begin
        ctrl.alu_b_sel = SRC_B_RS2;
        ctrl.word_op   = (opcode == OP_32);
        ctrl.reg_write = 1'b1;
        ctrl.alu_op    = alu_of_f3(funct3, funct7 == F7_ALT);
        if (funct7 != F7_BASE && !(funct7 == F7_ALT && funct3 inside {3'b000, 3'b101}))
          legal = 1'b0;
        if (opcode == OP_32 && !(funct3 inside {3'b000, 3'b001, 3'b101}))
          legal = 1'b0;
      end
      OP_IMM: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_op    = alu_of_f3(funct3, funct3 == 3'b101 && i_inst[30]);
        if (funct3 == 3'b001 && i_inst[31:26] != 6'b000000)
          legal = 1'b0;
        if (funct3 == 3'b101 && !(i_inst[31:26] inside {6'b000000, 6'b010000}))
          legal = 1'b0;
      end
      OP_IMM_32: begin
        ctrl.word_op   = 1'b1;
        ctrl.reg_write = 1'b1;
        ctrl.alu_op    = alu_of_f3(funct3, funct3 == 3'b101 && funct7 == F7_ALT);
        if (!(funct3 inside {3'b000, 3'b001, 3'b101}))
          legal = 1'b0;
        if (funct3 == 3'b001 && funct7 != F7_BASE)
          legal = 1'b0;
        if (funct3 == 3'b101 && !(funct7 inside {F7_BASE, F7_ALT}))
          legal = 1'b0;
      end
      LUI: begin
        ctrl.alu_op    = ALU_COPY_B;
        ctrl.reg_write = 1'b1;
      end
      AUIPC: begin
        ctrl.alu_a_pc  = 1'b1;
        ctrl.reg_write = 1'b1;
      end
      JAL, JALR: begin
        // alu also forms the link value pc+4
        ctrl.alu_a_pc  = 1'b1;
        ctrl.alu_b_sel = SRC_B_FOUR;
        ctrl.reg_write = 1'b1;
        ctrl.branch    = (opcode == JAL) ? BR_JAL : BR_JALR;
        if (opcode == JALR && funct3 != 3'b000)
          legal = 1'b0;
      end
      BRANCH: begin
        ctrl.alu_b_sel = SRC_B_RS2;
        ctrl.alu_op    = ALU_SUB;
        case (funct3)
          3'b000:  ctrl.branch = BR_EQ;
          3'b001:  ctrl.branch = BR_NE;
          3'b100:  ctrl.branch = BR_LT;
          3'b101:  ctrl.branch = BR_GE;
          3'b110:  ctrl.branch = BR_LTU;
          3'b111:  ctrl.branch = BR_GEU;
          default: legal = 1'b0;
        endcase
      end
      LOAD: begin
        ctrl.mem_read  = 1'b1;
        ctrl.reg_write = 1'b1;
        case (funct3)
          3'b000:  ctrl.mem_op = LD_B;
          3'b001:  ctrl.mem_op = LD_H;
          3'b010:  ctrl.mem_op = LD_W;
          3'b011:  ctrl.mem_op = LD_D;
          3'b100:  ctrl.mem_op = LD_BU;
          3'b101:  ctrl.mem_op = LD_HU;
          3'b110:  ctrl.mem_op = LD_WU;
          default: legal = 1'b0;
        endcase
      end
      STORE: begin
        // sd only
        ctrl.mem_write = 1'b1;
        if (funct3 != 3'b011)
          legal = 1'b0;
      end
      default: legal = 1'b0;
    endcase
    if (!legal) begin
      ctrl.branch    = BR_NONE;
      ctrl.mem_read  = 1'b0;
      ctrl.mem_write = 1'b0;
      ctrl.reg_write = 1'b0;
      ctrl.illegal   = 1'b1;
    end
  end

  assign o_ctrl = ctrl;

endmodule

`default_nettype wire

// ==== source/int_alu.sv ====
// integer alu with operand select, word cut, compare and shifts
`default_nettype none

module int_alu import rv64_core_pkg::*; (
  input  ctrl_t                 i_ctrl,
  input  wire logic [XLEN-1:0]  i_rs1,
  input  wire logic [XLEN-1:0]  i_rs2,
  input  wire logic [XLEN-1:0]  i_imm,
  input  wire logic [XLEN-1:0]  i_pc,
  output logic [XLEN-1:0]       o_result,
  output logic                  o_less,
  output logic                  o_zero
);

  logic [XLEN-1:0] opd_a;
  logic [XLEN-1:0] opd_b;
  logic [XLEN-1:0] src_a;
  logic [XLEN-1:0] src_b;
  logic [XLEN-1:0] sub_res;
  logic [XLEN-1:0] sra_src;
  logic [XLEN-1:0] raw;
  logic [5:0]      shamt;
  logic            less_s;
  logic            less_u;
  logic            cmp_unsigned;

  assign opd_a = i_ctrl.alu_a_pc ? i_pc : i_rs1;

  always_comb begin
    case (i_ctrl.alu_b_sel)
      SRC_B_RS2: opd_b = i_rs2;
      SRC_B_IMM: opd_b = i_imm;
      default:   opd_b = XLEN'(4);
    endcase
  end

  // word ops see only the low 32 bits
  assign src_a = i_ctrl.word_op ? {32'b0, opd_a[31:0]} : opd_a;
  assign src_b = i_ctrl.word_op ? {32'b0, opd_b[31:0]} : opd_b;

  assign shamt   = i_ctrl.word_op ? {1'b0, src_b[4:0]} : src_b[5:0];
  assign sra_src = i_ctrl.word_op ? {{32{src_a[31]}}, src_a[31:0]} : src_a;

  assign sub_res = src_a - src_b;
  assign less_s  = $signed(src_a) < $signed(src_b);
  assign less_u  = src_a < src_b;

  assign cmp_unsigned = (i_ctrl.branch == BR_LTU) || (i_ctrl.branch == BR_GEU);
  assign o_less       = cmp_unsigned ? less_u : less_s;
  assign o_zero       = (sub_res == '0);

  always_comb begin
    case (i_ctrl.alu_op)
      ALU_ADD:    raw = src_a + src_b;
      ALU_SUB:    raw = sub_res;
      ALU_SLT:    raw = XLEN'(less_s);
      ALU_SLTU:   raw = XLEN'(less_u);
      ALU_XOR:    raw = src_a ^ src_b;
      ALU_AND:    raw = src_a & src_b;
      ALU_OR:     raw = src_a | src_b;
      ALU_SLL:    raw = src_a << shamt;
      ALU_SRL:    raw = src_a >> shamt;
      ALU_SRA:    raw = $unsigned($signed(sra_src) >>> shamt);
      ALU_COPY_B: raw = src_b;
      default:    raw = '0;
    endcase
  end

  // sign extend word results from bit 31
  assign o_result = i_ctrl.word_op ? {{32{raw[31]}}, raw[31:0]} : raw;

endmodule

`default_nettype wire

// ==== source/pc_unit.sv ====
// program counter, branch decision and next pc
`default_nettype none

module pc_unit import rv64_core_pkg::*; (
  input  wire logic             i_clk,
  input  wire logic             i_rst_n,
  input  ctrl_t                 i_ctrl,
  input  wire logic [XLEN-1:0]  i_imm,
  input  wire logic [XLEN-1:0]  i_rs1,
  input  wire logic             i_less,
  input  wire logic             i_zero,
  output logic [XLEN-1:0]       o_pc,
  output logic [XLEN-1:0]       o_link_pc
);

  logic [XLEN-1:0] pc_q;
  logic [XLEN-1:0] target;
  logic [XLEN-1:0] next_pc;
  logic            taken;

  always_comb begin
    case (i_ctrl.branch)
      BR_JAL, BR_JALR: taken = 1'b1;
      BR_EQ:           taken = i_zero;
      BR_NE:           taken = ~i_zero;
      BR_LT, BR_LTU:   taken = i_less;
      BR_GE, BR_GEU:   taken = ~i_less;
      default:         taken = 1'b0;
    endcase
  end

  assign target  = ((i_ctrl.branch == BR_JALR) ? i_rs1 : pc_q) + (taken ? i_imm : XLEN'(4));
  // jalr clears bit 0
  assign next_pc = (i_ctrl.branch == BR_JALR) ? {target[XLEN-1:1], 1'b0} : target;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      pc_q <= RESET_PC;
    end else begin
      pc_q <= next_pc;
    end
  end

  assign o_pc      = pc_q;
  assign o_link_pc = pc_q + XLEN'(4);

endmodule

`default_nettype wire

// ==== source/reg_file.sv ====
// 32 x 64 integer register file, x0 reads zero
`default_nettype none

module reg_file import rv64_core_pkg::*; (
  input  wire logic                  i_clk,
  input  wire logic                  i_rst_n,
  input  wire logic                  i_we,
  input  wire logic [REG_IDX_W-1:0]  i_rd_idx,
  input  wire logic [XLEN-1:0]       i_rd_data,
  input  wire logic [REG_IDX_W-1:0]  i_rs1_idx,
  input  wire logic [REG_IDX_W-1:0]  i_rs2_idx,
  output logic [XLEN-1:0]            o_rs1_data,
  output logic [XLEN-1:0]            o_rs2_data
);

  logic [XLEN-1:0] regs [1:NUM_REGS-1];

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 1; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && i_rd_idx != '0) begin
      regs[i_rd_idx] <= i_rd_data;
    end
  end

  assign o_rs1_data = (i_rs1_idx == '0) ? '0 : regs[i_rs1_idx];
  assign o_rs2_data = (i_rs2_idx == '0) ? '0 : regs[i_rs2_idx];

endmodule

`default_nettype wire

// ==== source/wb_select.sv ====
// load extension and register write-back select
`default_nettype none

module wb_select import rv64_core_pkg::*; (
  input  ctrl_t                 i_ctrl,
  input  wire logic [XLEN-1:0]  i_alu_result,
  input  wire logic [XLEN-1:0]  i_rdata,
  input  wire logic [XLEN-1:0]  i_link_pc,
  output logic [XLEN-1:0]       o_rd_data,
  output logic                  o_rd_we
);

  logic [XLEN-1:0] load_data;

  always_comb begin
    case (i_ctrl.mem_op)
      LD_B:    load_data = {{56{i_rdata[7]}}, i_rdata[7:0]};
      LD_BU:   load_data = {56'b0, i_rdata[7:0]};
      LD_H:    load_data = {{48{i_rdata[15]}}, i_rdata[15:0]};
      LD_HU:   load_data = {48'b0, i_rdata[15:0]};
      LD_W:    load_data = {{32{i_rdata[31]}}, i_rdata[31:0]};
      LD_WU:   load_data = {32'b0, i_rdata[31:0]};
      default: load_data = i_rdata;
    endcase
  end

  always_comb begin
    if (i_ctrl.mem_read) o_rd_data = load_data;
    else if (i_ctrl.branch inside {BR_JAL, BR_JALR}) o_rd_data = i_link_pc;
    else o_rd_data = i_alu_result;
  end

  // decoder already clears this for illegal encodings
  assign o_rd_we = i_ctrl.reg_write;

endmodule

`default_nettype wire

// ==== source/rv64_core.sv ====
// single-cycle rv64i core top level
`default_nettype none

module rv64_core import rv64_core_pkg::*; (
  input  wire logic             i_clk,
  input  wire logic             i_rst_n,
  output logic [XLEN-1:0]       o_pc,
  input  wire logic [31:0]      i_inst,
  output logic [XLEN-1:0]       o_daddr,
  output logic                  o_dwe,
  output logic [XLEN-1:0]       o_wdata,
  input  wire logic [XLEN-1:0]  i_rdata,
  output logic                  o_illegal
);

  ctrl_t                ctrl;
  logic [XLEN-1:0]      imm;
  logic [REG_IDX_W-1:0] rs1_idx;
  logic [REG_IDX_W-1:0] rs2_idx;
  logic [REG_IDX_W-1:0] rd_idx;
  logic [XLEN-1:0]      rs1_data;
  logic [XLEN-1:0]      rs2_data;
  logic [XLEN-1:0]      alu_result;
  logic [XLEN-1:0]      link_pc;
  logic [XLEN-1:0]      rd_data;
  logic                 rd_we;
  logic                 less;
  logic                 zero;

  inst_decoder i_inst_decoder (
    .i_inst(i_inst), .o_ctrl(ctrl), .o_imm(imm),
    .o_rs1_idx(rs1_idx), .o_rs2_idx(rs2_idx), .o_rd_idx(rd_idx)
  );

  reg_file i_reg_file (
    .i_clk(i_clk), .i_rst_n(i_rst_n), .i_we(rd_we), .i_rd_idx(rd_idx), .i_rd_data(rd_data),
    .i_rs1_idx(rs1_idx), .i_rs2_idx(rs2_idx), .o_rs1_data(rs1_data), .o_rs2_data(rs2_data)
  );

  int_alu i_int_alu (
    .i_ctrl(ctrl), .i_rs1(rs1_data), .i_rs2(rs2_data), .i_imm(imm), .i_pc(o_pc),
    .o_result(alu_result), .o_less(less), .o_zero(zero)
  );

  pc_unit i_pc_unit (
    .i_clk(i_clk), .i_rst_n(i_rst_n), .i_ctrl(ctrl), .i_imm(imm), .i_rs1(rs1_data),
    .i_less(less), .i_zero(zero), .o_pc(o_pc), .o_link_pc(link_pc)
  );

  wb_select i_wb_select (
    .i_ctrl(ctrl), .i_alu_result(alu_result), .i_rdata(i_rdata), .i_link_pc(link_pc),
    .o_rd_data(rd_data), .o_rd_we(rd_we)
  );

  assign o_daddr   = alu_result;
  assign o_wdata   = rs2_data;
  assign o_dwe     = ctrl.mem_write;
  assign o_illegal = ctrl.illegal;

endmodule

`default_nettype wire

// ==== sim/rv64_core_sva.sv ====
// concurrent assertions on the rv64 core outputs, bound into the top level
`default_nettype none

module rv64_core_sva import rv64_core_pkg::*; (
  input wire logic            i_clk,
  input wire logic            i_rst_n,
  input wire logic [XLEN-1:0] i_pc,
  input wire logic            i_dwe,
  input wire logic            i_illegal,
  input wire ctrl_t           i_ctrl
);
  timeunit 1ns;
  timeprecision 100ps;

  int unsigned fail_count = 0;

  // an illegal encoding never stores
  a_no_store_when_illegal: assert property (
    @(posedge i_clk) disable iff (!i_rst_n) !(i_dwe && i_illegal)
  ) else begin
    fail_count = fail_count + 1;
    $error("store enable and illegal flag are high together");
  end

  a_pc_aligned: assert property (
    @(posedge i_clk) disable iff (!i_rst_n) (i_ctrl.branch != BR_JALR) |=> (i_pc[1:0] == 2'b00)
  ) else begin
    fail_count = fail_count + 1;
    $error("pc is not a multiple of 4");
  end

  a_pc_in_reset: assert property (
    @(posedge i_clk) !i_rst_n |-> (i_pc == RESET_PC)
  ) else begin
    fail_count = fail_count + 1;
    $error("pc left its reset value while reset is low");
  end

endmodule

`default_nettype wire

// ==== sim/rv64_core_tb.sv ====
// testbench for the rv64 core with random instructions, ISA model and memory model
`default_nettype none

module rv64_core_tb import rv64_core_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_INSTS    = 2000;
  localparam int RESET_CYCLES = 8;
  localparam int MAX_CYCLES   = NUM_INSTS + RESET_CYCLES + 100;

  logic            i_clk;
  logic            i_rst_n;
  logic [31:0]     i_inst;
  logic [XLEN-1:0] i_rdata;
  logic [XLEN-1:0] o_pc;
  logic [XLEN-1:0] o_daddr;
  logic [XLEN-1:0] o_wdata;
  logic            o_dwe;
  logic            o_illegal;

  integer seed;
  int     errors;
  int     cycles = 0;

  // reference model state
  logic [XLEN-1:0] m_pc;
  logic [XLEN-1:0] m_regs [32];
  logic [XLEN-1:0] mem [logic [XLEN-1:0]];

  // expected effects of the current instruction
  logic [XLEN-1:0] exp_next_pc;
  logic [XLEN-1:0] exp_daddr;
  logic [XLEN-1:0] exp_wdata;
  logic            exp_dwe;
  logic            exp_illegal;
  logic            exp_addr_chk;
  logic            wb_en;
  logic [4:0]      wb_rd;
  logic [XLEN-1:0] wb_val;

  rv64_core i_rv64_core (
    .i_clk(i_clk), .i_rst_n(i_rst_n), .o_pc(o_pc), .i_inst(i_inst),
    .o_daddr(o_daddr), .o_dwe(o_dwe), .o_wdata(o_wdata), .i_rdata(i_rdata),
    .o_illegal(o_illegal)
  );

  bind rv64_core rv64_core_sva i_rv64_core_sva (
    .i_clk(i_clk), .i_rst_n(i_rst_n), .i_pc(o_pc), .i_dwe(o_dwe),
    .i_illegal(o_illegal), .i_ctrl(ctrl)
  );

  initial i_clk = 1'b0;
  always #20 i_clk = ~i_clk;

  always @(posedge i_clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: the run went past %0d cycles without finishing", MAX_CYCLES);
      $display("Checks failed");
      $finish;
    end
  end

  function automatic int unsigned rand_below(input int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  // unwritten locations hold a pattern of the full address
  function automatic logic [XLEN-1:0] mem_word(input logic [XLEN-1:0] addr);
    if (mem.exists(addr))
      return mem[addr];
    return (addr * 64'h9e37_79b9_7f4a_7c15) ^ {addr[31:0], addr[63:32]};
  endfunction

  // rv64i arithmetic as the ISA defines it
  function automatic logic [XLEN-1:0] alu_ref(input logic [2:0] f3, input logic alt,
      input logic word, input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
    logic [XLEN-1:0] r;
    logic [31:0]     w;
    if (word) begin
      case (f3)
        3'd0: w = alt ? a[31:0] - b[31:0] : a[31:0] + b[31:0];
        3'd1: w = a[31:0] << b[4:0];
        default: begin
          if (alt)
            w = $signed(a[31:0]) >>> b[4:0];
          else
            w = a[31:0] >> b[4:0];
        end
      endcase
      r = {{32{w[31]}}, w};
    end else begin
      case (f3)
        3'd0: r = alt ? a - b : a + b;
        3'd1: r = a << b[5:0];
        3'd2: r = {63'b0, $signed(a) < $signed(b)};
        3'd3: r = {63'b0, a < b};
        3'd4: r = a ^ b;
        3'd5: begin
          if (alt)
            r = $signed(a) >>> b[5:0];
          else
            r = a >> b[5:0];
        end
        3'd6: r = a | b;
        default: r = a & b;
      endcase
    end
    return r;
  endfunction

  task automatic issue_instruction();
    int unsigned     kind;
    int              off;
    logic [4:0]      rd;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [2:0]      f3;
    logic            alt;
    logic            taken;
    logic [11:0]     i12;
    logic [31:0]     inst;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] t;
    logic [XLEN-1:0] rdata;
    kind = rand_below(16);
    rd = 5'(rand_below(32));
    rs1 = 5'(rand_below(32));
    rs2 = 5'(rand_below(32));
    f3 = 3'(rand_below(8));
    alt = 1'(rand_below(2));
    i12 = 12'(rand_below(4096));
    // half of the loads and stores share a few x0-based addresses
    if (kind >= 11 && alt) begin
      rs1 = 5'd0;
      i12 = 12'(rand_below(8) * 8);
    end
    a = m_regs[rs1];
    b = m_regs[rs2];
    rdata = {$random(seed), $random(seed)};
    exp_next_pc = m_pc + 64'd4;
    exp_dwe = 1'b0;
    exp_illegal = 1'b0;
    exp_addr_chk = 1'b0;
    wb_en = 1'b1;
    wb_rd = rd;
    wb_val = '0;
    case (kind)
      0: begin
        exp_illegal = 1'b1;
        wb_en = 1'b0;
        case (rand_below(6))
          0: inst = 32'h0;
          1: inst = {7'b0000001, rs2, rs1, f3, rd, OP};
          2: inst = {7'(rand_below(128)), rs2, rs1, 3'(rand_below(3)), rd, STORE};
          3: inst = {i12, rs1, 3'b111, rd, LOAD};
          4: inst = {7'(rand_below(128)), rs2, rs1, 2'b01, alt, rd, BRANCH};
          default: inst = {i12, rs1, f3, rd, 7'b1110011};
        endcase
      end
      1, 2: begin
        if (!(f3 inside {3'd0, 3'd5}))
          alt = 1'b0;
        inst = {1'b0, alt, 5'b0, rs2, rs1, f3, rd, OP};
        wb_val = alu_ref(f3, alt, 1'b0, a, b);
      end
      3, 4: begin
        if (f3 != 3'd5)
          alt = 1'b0;
        if (f3 == 3'd1)
          i12 = {6'b0, i12[5:0]};
        if (f3 == 3'd5)
          i12 = {1'b0, alt, 4'b0, i12[5:0]};
        inst = {i12, rs1, f3, rd, OP_IMM};
        wb_val = alu_ref(f3, alt, 1'b0, a, {{52{i12[11]}}, i12});
      end
      5, 6: begin
        f3 = (f3 < 3) ? 3'd0 : (f3 < 6) ? 3'd1 : 3'd5;
        if (f3 == 3'd1)
          alt = 1'b0;
        if (kind == 5) begin
          inst = {1'b0, alt, 5'b0, rs2, rs1, f3, rd, OP_32};
          wb_val = alu_ref(f3, alt, 1'b1, a, b);
        end else begin
          if (f3 != 3'd0)
            i12 = {1'b0, alt, 5'b0, i12[4:0]};
          inst = {i12, rs1, f3, rd, OP_IMM_32};
          wb_val = alu_ref(f3, alt && f3 == 3'd5, 1'b1, a, {{52{i12[11]}}, i12});
        end
      end
      7: begin
        t = {$random(seed), $random(seed)};
        imm = {{32{t[19]}}, t[19:0], 12'b0};
        inst = {t[19:0], rd, alt ? AUIPC : LUI};
        wb_val = alt ? m_pc + imm : imm;
      end
      8: begin
        wb_val = m_pc + 64'd4;
        if (alt) begin
          off = (int'(rand_below(33)) - 16) * 4;
          imm = {{32{off[31]}}, off};
          inst = {imm[20], imm[10:1], imm[11], imm[19:12], rd, JAL};
          exp_next_pc = m_pc + imm;
        end else begin
          // aligned target, sometimes with bit 0 set before clearing
          off = (int'(rand_below(33)) - 16) * 4 - int'(a[1:0]) + int'(rand_below(2));
          imm = {{32{off[31]}}, off};
          inst = {imm[11:0], rs1, 3'b000, rd, JALR};
          t = a + imm;
          exp_next_pc = {t[63:1], 1'b0};
        end
      end
      9, 10: begin
        wb_en = 1'b0;
        if (f3[2:1] == 2'b01)
          f3 = {1'b1, f3[1:0]};
        off = (int'(rand_below(17)) - 8) * 4;
        imm = {{32{off[31]}}, off};
        inst = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], BRANCH};
        case (f3)
          3'd0: taken = (a == b);
          3'd1: taken = (a != b);
          3'd4: taken = $signed(a) < $signed(b);
          3'd5: taken = $signed(a) >= $signed(b);
          3'd6: taken = a < b;
          default: taken = a >= b;
        endcase
        if (taken)
          exp_next_pc = m_pc + imm;
      end
      11, 12: begin
        if (f3 == 3'd7)
          f3 = 3'd3;
        inst = {i12, rs1, f3, rd, LOAD};
        exp_addr_chk = 1'b1;
        exp_daddr = a + {{52{i12[11]}}, i12};
        rdata = mem_word(exp_daddr);
        case (f3)
          3'd0: wb_val = {{56{rdata[7]}}, rdata[7:0]};
          3'd1: wb_val = {{48{rdata[15]}}, rdata[15:0]};
          3'd2: wb_val = {{32{rdata[31]}}, rdata[31:0]};
          3'd4: wb_val = {56'b0, rdata[7:0]};
          3'd5: wb_val = {48'b0, rdata[15:0]};
          3'd6: wb_val = {32'b0, rdata[31:0]};
          default: wb_val = rdata;
        endcase
      end
      default: begin
        wb_en = 1'b0;
        inst = {i12[11:5], rs2, rs1, 3'b011, i12[4:0], STORE};
        exp_dwe = 1'b1;
        exp_addr_chk = 1'b1;
        exp_daddr = a + {{52{i12[11]}}, i12};
        exp_wdata = b;
      end
    endcase
    i_inst = inst;
    i_rdata = rdata;
  endtask

  task automatic check_outputs();
    if (o_pc !== m_pc) begin
      errors++;
      $display("Mismatch at %0t: pc is %h, expected %h", $time, o_pc, m_pc);
    end
    if (o_illegal !== exp_illegal) begin
      errors++;
      $display("Mismatch at %0t: inst %h illegal is %b, expected %b",
               $time, i_inst, o_illegal, exp_illegal);
    end
    if (o_dwe !== exp_dwe) begin
      errors++;
      $display("Mismatch at %0t: inst %h dwe is %b, expected %b", $time, i_inst, o_dwe, exp_dwe);
    end
    if (exp_addr_chk && o_daddr !== exp_daddr) begin
      errors++;
      $display("Mismatch at %0t: inst %h daddr is %h, expected %h",
               $time, i_inst, o_daddr, exp_daddr);
    end
    if (exp_dwe && o_wdata !== exp_wdata) begin
      errors++;
      $display("Mismatch at %0t: inst %h wdata is %h, expected %h",
               $time, i_inst, o_wdata, exp_wdata);
    end
  endtask

  task automatic commit_model();
    if (wb_en && wb_rd != 5'd0)
      m_regs[wb_rd] = wb_val;
    if (exp_dwe)
      mem[exp_daddr] = exp_wdata;
    m_pc = exp_next_pc;
  endtask

  initial begin
    seed = 32'h3266;
    errors = 0;
    i_rst_n = 1'b1;
    i_inst = 32'h0000_0013;
    i_rdata = '0;
    m_pc = RESET_PC;
    for (int r = 0; r < 32; r++) begin
      m_regs[r] = '0;
    end
    // reset falls after time zero so the pc register sees the edge
    #1;
    i_rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge i_clk);
    #2;
    i_rst_n = 1'b1;
    for (int n = 0; n < NUM_INSTS; n++) begin
      issue_instruction();
      // sample just before the next edge
      #36;
      check_outputs();
      commit_model();
      @(posedge i_clk);
      #2;
    end
    $display("%0d mismatches, %0d assertion failures",
             errors, i_rv64_core.i_rv64_core_sva.fail_count);
    if (errors == 0 && i_rv64_core.i_rv64_core_sva.fail_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== rv64_core.f ====
source/rv64_core_pkg.sv
source/inst_decoder.sv
source/int_alu.sv
source/pc_unit.sv
source/reg_file.sv
source/wb_select.sv
source/rv64_core.sv
sim/rv64_core_sva.sv
sim/rv64_core_tb.sv

// ==== Bender.yml ====
package:
  name: rv64_core

sources:
  - source/rv64_core_pkg.sv
  - source/inst_decoder.sv
  - source/int_alu.sv
  - source/pc_unit.sv
  - source/reg_file.sv
  - source/wb_select.sv
  - source/rv64_core.sv
  - target: simulation
    files:
      - sim/rv64_core_sva.sv
      - sim/rv64_core_tb.sv
